//--- common/wb_pkg.sv
`default_nettype none

package wb_pkg;

  ////////////////////
  // Datapath widths
  ////////////////////

  // Register and operand width
  localparam int XLEN = 32;

  // Register file address width and depth
  localparam int RF_ADDR_W = 5;
  localparam int RF_DEPTH  = 32;

  // Shift amount taken from the low bits of operand B
  localparam int SHAMT_W = 5;

  ////////////////////
  // Data memory
  ////////////////////

  // Depth in words, word addresses at or above it fault
  localparam int DMEM_WORDS = 64;

  // Word address field from operand A, wider than the index
  // so that out-of-range addresses can be issued
  localparam int DMEM_ADDR_W = 8;

  // Index into the memory array
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

  // Largest number of wait states and the counter width
  localparam int LSU_MAX_WAIT = 3;
  localparam int LSU_WAIT_W   = $clog2(LSU_MAX_WAIT + 1);

  ////////////////////
  // Encodings
  ////////////////////

  // Decoded opcode as it arrives on the issue port
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_XOR   = 3'd2,
    OP_SLL   = 3'd3,
    OP_LOAD  = 3'd4,
    OP_STORE = 3'd5,
    OP_XIF   = 3'd6
  } op_e;

  // Range check result from the LSU
  typedef enum logic {
    MPU_OK    = 1'b0,
    MPU_FAULT = 1'b1
  } mpu_status_e;

endpackage

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_i,

  // Write port from write-back
  input  logic                 we_i,
  input  logic [RF_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]      wdata_i,

  // Inspection read port
  input  logic [RF_ADDR_W-1:0] raddr_i,
  output logic [XLEN-1:0]      rdata_o
);

  logic [XLEN-1:0] regs [RF_DEPTH];

  ////////////////////
  // Write
  ////////////////////

  // All entries start at zero, x0 is never written
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < RF_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  ////////////////////
  // Read
  ////////////////////

  // Asynchronous, x0 forced to zero
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

`default_nettype wire

//--- ex/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import wb_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_i,

  // Issue port
  input  logic                   issue_valid_i,
  input  op_e                    issue_op_i,
  input  logic [RF_ADDR_W-1:0]   issue_rd_i,
  input  logic [XLEN-1:0]        issue_opa_i,
  input  logic [XLEN-1:0]        issue_opb_i,
  output logic                   issue_ready_o,

  // Back-pressure from write-back
  input  logic                   wb_ready_i,

  // LSU request, valid for the advancing cycle only
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output logic [DMEM_ADDR_W-1:0] lsu_addr_o,
  output logic [XLEN-1:0]        lsu_wdata_o,

  // EX/WB pipeline register
  output logic                   ex_wb_valid_o,
  output op_e                    ex_wb_op_o,
  output logic [RF_ADDR_W-1:0]   ex_wb_rd_o,
  output logic [XLEN-1:0]        ex_wb_result_o
);

  logic                 advance;
  logic                 issue_fire;
  logic                 is_mem;
  logic [XLEN-1:0]      alu_result;

  logic                 ex_wb_valid_q;
  op_e                  ex_wb_op_q;
  logic [RF_ADDR_W-1:0] ex_wb_rd_q;
  logic [XLEN-1:0]      ex_wb_result_q;

  ////////////////////
  // Stage handshake
  ////////////////////

  // Register moves when WB takes its content or when it is empty
  assign advance       = wb_ready_i || !ex_wb_valid_q;
  assign issue_ready_o = advance;
  assign issue_fire    = issue_valid_i && advance;

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    unique case (issue_op_i)
      OP_ADD:  alu_result = issue_opa_i + issue_opb_i;
      OP_SUB:  alu_result = issue_opa_i - issue_opb_i;
      OP_XOR:  alu_result = issue_opa_i ^ issue_opb_i;
      // Shift amount is the low bits of operand B only
      OP_SLL:  alu_result = issue_opa_i << issue_opb_i[SHAMT_W-1:0];
      // Memory and offloaded results come from elsewhere in WB
      default: alu_result = '0;
    endcase
  end

  ////////////////////
  // LSU launch
  ////////////////////

  assign is_mem      = (issue_op_i == OP_LOAD) || (issue_op_i == OP_STORE);
  assign lsu_req_o   = issue_fire && is_mem;
  assign lsu_we_o    = (issue_op_i == OP_STORE);
  // Word address from the low bits of operand A
  assign lsu_addr_o  = issue_opa_i[DMEM_ADDR_W-1:0];
  assign lsu_wdata_o = issue_opb_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  // Valid bit, cleared when the register advances with nothing behind it
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_wb_valid_q <= 1'b0;
    end else if (advance) begin
      ex_wb_valid_q <= issue_valid_i;
    end
  end

  // Payload only loads on a transfer
  always_ff @(posedge clk) begin
    if (issue_fire) begin
      ex_wb_op_q     <= issue_op_i;
      ex_wb_rd_q     <= issue_rd_i;
      ex_wb_result_q <= alu_result;
    end
  end

  assign ex_wb_valid_o  = ex_wb_valid_q;
  assign ex_wb_op_o     = ex_wb_op_q;
  assign ex_wb_rd_o     = ex_wb_rd_q;
  assign ex_wb_result_o = ex_wb_result_q;

endmodule

`default_nettype wire

//--- lsu/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import wb_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_i,

  // Request from EX
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  logic [DMEM_ADDR_W-1:0] lsu_addr_i,
  input  logic [XLEN-1:0]        lsu_wdata_i,

  // Response toward WB
  input  logic                   lsu_ready_i,
  output logic                   lsu_valid_o,
  output logic [XLEN-1:0]        lsu_rdata_o,
  output mpu_status_e            lsu_mpu_status_o
);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_WAIT,
    LSU_RESP
  } lsu_state_e;

  lsu_state_e             state_q;
  mpu_status_e            status_q;
  logic [LSU_WAIT_W-1:0]  wait_ctr_q;
  logic [LSU_WAIT_W-1:0]  remain_q;

  // Latched request for waited accesses
  logic                   we_q;
  logic [DMEM_IDX_W-1:0]  idx_q;
  logic [XLEN-1:0]        wdata_q;

  logic [XLEN-1:0]        mem [DMEM_WORDS];
  logic [XLEN-1:0]        rdata_q;

  logic                   accept;
  logic                   in_range;
  logic                   acc_now;
  logic                   acc_late;
  logic                   acc_we;
  logic [DMEM_IDX_W-1:0]  acc_idx;
  logic [XLEN-1:0]        acc_wdata;

  ////////////////////
  // Request decode
  ////////////////////

  // A held response is released only once WB can take the next one
  assign accept   = lsu_req_i &&
                    ((state_q == LSU_IDLE) || ((state_q == LSU_RESP) && lsu_ready_i));
  // Range check on the full address field
  assign in_range = (lsu_addr_i < DMEM_ADDR_W'(DMEM_WORDS));

  // Zero wait states: access on the request edge
  assign acc_now  = accept && in_range && (wait_ctr_q == '0);
  // Otherwise on the last wait cycle, with latched fields
  assign acc_late = (state_q == LSU_WAIT) && (remain_q == LSU_WAIT_W'(1));

  assign acc_we    = acc_now ? lsu_we_i : we_q;
  assign acc_idx   = acc_now ? lsu_addr_i[DMEM_IDX_W-1:0] : idx_q;
  assign acc_wdata = acc_now ? lsu_wdata_i : wdata_q;

  ////////////////////
  // Wait-state source
  ////////////////////

  // Free-running, sampled at each accepted request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wait_ctr_q <= '0;
    end else begin
      wait_ctr_q <= wait_ctr_q + LSU_WAIT_W'(1);
    end
  end

  ////////////////////
  // Access FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q  <= LSU_IDLE;
      status_q <= MPU_OK;
      remain_q <= '0;
    end else begin
      unique case (state_q)
        LSU_IDLE, LSU_RESP: begin
          if (accept) begin
            if (!in_range) begin
              // Fault answers next cycle, memory untouched
              state_q  <= LSU_RESP;
              status_q <= MPU_FAULT;
            end else if (wait_ctr_q == '0) begin
              state_q  <= LSU_RESP;
              status_q <= MPU_OK;
            end else begin
              state_q  <= LSU_WAIT;
              status_q <= MPU_OK;
              remain_q <= wait_ctr_q;
            end
          end
        end
        LSU_WAIT: begin
          if (remain_q == LSU_WAIT_W'(1)) begin
            state_q <= LSU_RESP;
          end else begin
            remain_q <= remain_q - LSU_WAIT_W'(1);
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  // Request fields held for the waited access
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= lsu_we_i;
      idx_q   <= lsu_addr_i[DMEM_IDX_W-1:0];
      wdata_q <= lsu_wdata_i;
    end
  end

  ////////////////////
  // Memory array
  ////////////////////

  // Cleared on reset so that every word starts at zero
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if ((acc_now || acc_late) && acc_we) begin
      mem[acc_idx] <= acc_wdata;
    end
  end

  // Read data register
  always_ff @(posedge clk) begin
    if ((acc_now || acc_late) && !acc_we) begin
      rdata_q <= mem[acc_idx];
    end
  end

  // Response stays up until the next request replaces it
  assign lsu_valid_o      = (state_q == LSU_RESP);
  assign lsu_rdata_o      = rdata_q;
  assign lsu_mpu_status_o = status_q;

endmodule

`default_nettype wire

//--- wb/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage import wb_pkg::*; (
  // Only the bound assertions use these
  input  logic                 clk,
  input  logic                 rst_i,

  // EX/WB register
  input  logic                 ex_wb_valid_i,
  input  op_e                  ex_wb_op_i,
  input  logic [RF_ADDR_W-1:0] ex_wb_rd_i,
  input  logic [XLEN-1:0]      ex_wb_result_i,

  input  logic                 halt_wb_i,

  // LSU response
  input  logic                 lsu_valid_i,
  input  logic [XLEN-1:0]      lsu_rdata_i,
  input  mpu_status_e          lsu_mpu_status_i,
  output logic                 lsu_ready_o,

  // Coprocessor result
  input  logic                 xif_result_valid_i,
  input  logic [XLEN-1:0]      xif_result_data_i,
  input  logic                 xif_result_exc_i,
  output logic                 xif_result_ready_o,

  // Register file write port
  output logic                 rf_we_o,
  output logic [RF_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]      rf_wdata_o,

  output logic                 wb_ready_o,
  output logic                 retire_valid_o,
  output logic [RF_ADDR_W-1:0] retire_rd_o,
  output logic                 retire_exc_o,
  output logic                 data_stall_o
);

  logic lsu_en;
  logic xif_en;
  logic op_writes;
  logic instr_valid;
  logic lsu_waiting;
  logic lsu_exception;
  logic xif_waiting;
  logic xif_exception;

  ////////////////////
  // Decode
  ////////////////////

  assign lsu_en    = (ex_wb_op_i == OP_LOAD) || (ex_wb_op_i == OP_STORE);
  assign xif_en    = (ex_wb_op_i == OP_XIF);
  // Everything except stores has a destination
  assign op_writes = (ex_wb_op_i != OP_STORE);

  // Halted instruction stays put, neither writes nor retires
  assign instr_valid = ex_wb_valid_i && !halt_wb_i;

  // LSU side
  assign lsu_waiting   = ex_wb_valid_i && lsu_en && !lsu_valid_i;
  // Ignore a stale response left over from an earlier access
  assign lsu_exception = lsu_en && lsu_valid_i && (lsu_mpu_status_i == MPU_FAULT);
  assign lsu_ready_o   = 1'b1;  // no downstream stage

  // Coprocessor side
  assign xif_waiting   = ex_wb_valid_i && xif_en && !xif_result_valid_i;
  assign xif_exception = ex_wb_valid_i && xif_en && xif_result_valid_i && xif_result_exc_i;
  // Not ready during halt, so the coprocessor keeps its result until retire
  assign xif_result_ready_o = ex_wb_valid_i && xif_en && !halt_wb_i;

  ////////////////////
  // Register file write
  ////////////////////

  // Load data is only written once it has arrived
  assign rf_we_o    = op_writes && instr_valid && !lsu_waiting && !lsu_exception &&
                      !xif_waiting && !xif_exception;
  assign rf_waddr_o = ex_wb_rd_i;
  assign rf_wdata_o = lsu_en ? lsu_rdata_i :
                      (xif_en ? xif_result_data_i : ex_wb_result_i);

  ////////////////////
  // Stage ready/valid
  ////////////////////

  assign wb_ready_o = !lsu_waiting && !xif_waiting && !halt_wb_i;

  // Faults retire too, flagged on retire_exc_o
  assign retire_valid_o = ((!lsu_en && !xif_waiting) ||
                           ( lsu_en && lsu_valid_i)) && instr_valid;
  assign retire_rd_o    = ex_wb_rd_i;
  assign retire_exc_o   = retire_valid_o && (lsu_exception || xif_exception);

  // Load or store in WB with its data still outstanding
  assign data_stall_o = lsu_waiting;

endmodule

`default_nettype wire

//--- src/exec_tail_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tail_top import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_i,

  // Issue port
  input  logic                 issue_valid_i,
  input  op_e                  issue_op_i,
  input  logic [RF_ADDR_W-1:0] issue_rd_i,
  input  logic [XLEN-1:0]      issue_opa_i,
  input  logic [XLEN-1:0]      issue_opb_i,
  output logic                 issue_ready_o,

  input  logic                 halt_wb_i,

  // Coprocessor result port
  input  logic                 xif_result_valid_i,
  input  logic [XLEN-1:0]      xif_result_data_i,
  input  logic                 xif_result_exc_i,
  output logic                 xif_result_ready_o,

  // Retire port
  output logic                 retire_valid_o,
  output logic [RF_ADDR_W-1:0] retire_rd_o,
  output logic                 retire_exc_o,
  output logic                 data_stall_o,

  // Register inspection
  input  logic [RF_ADDR_W-1:0] rf_raddr_i,
  output logic [XLEN-1:0]      rf_rdata_o
);

  // EX to WB
  logic                   ex_wb_valid;
  op_e                    ex_wb_op;
  logic [RF_ADDR_W-1:0]   ex_wb_rd;
  logic [XLEN-1:0]        ex_wb_result;
  logic                   wb_ready;

  // EX to LSU
  logic                   lsu_req;
  logic                   lsu_we;
  logic [DMEM_ADDR_W-1:0] lsu_addr;
  logic [XLEN-1:0]        lsu_wdata;

  // LSU to WB
  logic                   lsu_valid;
  logic                   lsu_ready;
  logic [XLEN-1:0]        lsu_rdata;
  mpu_status_e            lsu_mpu_status;

  // WB to register file
  logic                   rf_we;
  logic [RF_ADDR_W-1:0]   rf_waddr;
  logic [XLEN-1:0]        rf_wdata;

  ex_stage ex_stage_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_op_i     (issue_op_i),
    .issue_rd_i     (issue_rd_i),
    .issue_opa_i    (issue_opa_i),
    .issue_opb_i    (issue_opb_i),
    .issue_ready_o  (issue_ready_o),
    .wb_ready_i     (wb_ready),
    .lsu_req_o      (lsu_req),
    .lsu_we_o       (lsu_we),
    .lsu_addr_o     (lsu_addr),
    .lsu_wdata_o    (lsu_wdata),
    .ex_wb_valid_o  (ex_wb_valid),
    .ex_wb_op_o     (ex_wb_op),
    .ex_wb_rd_o     (ex_wb_rd),
    .ex_wb_result_o (ex_wb_result)
  );

  load_store_unit load_store_unit_inst (
    .clk              (clk),
    .rst_i            (rst_i),
    .lsu_req_i        (lsu_req),
    .lsu_we_i         (lsu_we),
    .lsu_addr_i       (lsu_addr),
    .lsu_wdata_i      (lsu_wdata),
    .lsu_ready_i      (lsu_ready),
    .lsu_valid_o      (lsu_valid),
    .lsu_rdata_o      (lsu_rdata),
    .lsu_mpu_status_o (lsu_mpu_status)
  );

  wb_stage wb_stage_inst (
    .clk                (clk),
    .rst_i              (rst_i),
    .ex_wb_valid_i      (ex_wb_valid),
    .ex_wb_op_i         (ex_wb_op),
    .ex_wb_rd_i         (ex_wb_rd),
    .ex_wb_result_i     (ex_wb_result),
    .halt_wb_i          (halt_wb_i),
    .lsu_valid_i        (lsu_valid),
    .lsu_rdata_i        (lsu_rdata),
    .lsu_mpu_status_i   (lsu_mpu_status),
    .lsu_ready_o        (lsu_ready),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_o (xif_result_ready_o),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_ready_o         (wb_ready),
    .retire_valid_o     (retire_valid_o),
    .retire_rd_o        (retire_rd_o),
    .retire_exc_o       (retire_exc_o),
    .data_stall_o       (data_stall_o)
  );

  register_file register_file_inst (
    .clk     (clk),
    .rst_i   (rst_i),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

`default_nettype wire

//--- bench/exec_tail_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tail_props import wb_pkg::*; (
  input logic        clk,
  input logic        rst_i,
  input logic        ex_wb_valid_i,
  input op_e         ex_wb_op_i,
  input logic        halt_wb_i,
  input logic        lsu_valid_i,
  input mpu_status_e lsu_mpu_status_i,
  input logic        xif_result_valid_i,
  input logic        xif_result_ready_o,
  input logic        rf_we_o,
  input logic        retire_valid_o
);

  // Count of failed properties
  int   fail_count = 0;
  logic mem_in_wb;

  assign mem_in_wb = ex_wb_valid_i && ((ex_wb_op_i == OP_LOAD) || (ex_wb_op_i == OP_STORE));

  // Faulting access never writes the register file
  no_write_on_fault: assert property (@(posedge clk) disable iff (rst_i)
    !(rf_we_o && mem_in_wb && lsu_valid_i && (lsu_mpu_status_i == MPU_FAULT)))
    else begin
      fail_count++;
      $error("register write together with an MPU fault");
    end

  // Ready only drops after the transfer, or while WB is halted
  xif_ready_held: assert property (@(posedge clk) disable iff (rst_i)
    (xif_result_ready_o && !xif_result_valid_i) |=> (xif_result_ready_o || halt_wb_i))
    else begin
      fail_count++;
      $error("xif_result_ready dropped before the result transferred");
    end

  no_retire_in_halt: assert property (@(posedge clk) disable iff (rst_i)
    halt_wb_i |-> !retire_valid_o)
    else begin
      fail_count++;
      $error("retire_valid high while write-back is halted");
    end

endmodule

`default_nettype wire

//--- bench/exec_tail_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tail_tb import wb_pkg::*; ();

  // Instructions per test, these also size the timeout
  localparam int N_ALU       = 12;
  localparam int N_STORE     = 8;
  localparam int N_FAULT     = 4;
  localparam int N_XIF       = 8;
  localparam int N_HALT      = 6;
  localparam int N_MIX       = 100;
  localparam int N_TOTAL     = N_ALU + 2 * N_STORE + 3 * N_FAULT + N_XIF + 2 * N_HALT + N_MIX;
  localparam int CYCLE_LIMIT = 200 * N_TOTAL;

  // Operand B value on which the coprocessor raises an exception
  localparam logic [XLEN-1:0] XIF_EXC_MARK = 32'hbad0_c0de;

  logic                 clk;
  logic                 rst_i;
  logic                 issue_valid_i;
  op_e                  issue_op_i;
  logic [RF_ADDR_W-1:0] issue_rd_i;
  logic [XLEN-1:0]      issue_opa_i;
  logic [XLEN-1:0]      issue_opb_i;
  logic                 issue_ready_o;
  logic                 halt_wb_i;
  logic                 xif_result_valid_i;
  logic [XLEN-1:0]      xif_result_data_i;
  logic                 xif_result_exc_i;
  logic                 xif_result_ready_o;
  logic                 retire_valid_o;
  logic [RF_ADDR_W-1:0] retire_rd_o;
  logic                 retire_exc_o;
  logic                 data_stall_o;
  logic [RF_ADDR_W-1:0] rf_raddr_i;
  logic [XLEN-1:0]      rf_rdata_o;

  // Shadow state and in-order expectations
  logic [XLEN-1:0]      shadow_rf [RF_DEPTH];
  logic [XLEN-1:0]      shadow_mem [DMEM_WORDS];
  op_e                  exp_op_q [$];
  logic [RF_ADDR_W-1:0] exp_rd_q [$];
  logic                 exp_exc_q [$];
  logic [XLEN-1:0]      xif_opa_q [$];
  logic [XLEN-1:0]      xif_opb_q [$];

  op_e                  ret_op;
  logic [RF_ADDR_W-1:0] ret_rd;
  logic                 ret_exc;
  logic                 stall_seen;
  int                   errors;
  int                   issued;
  int                   retired;
  int                   tests;
  int                   cycles;

  exec_tail_top exec_tail_top_inst (.*);

  bind wb_stage exec_tail_props props_inst (
    .clk                (clk),
    .rst_i              (rst_i),
    .ex_wb_valid_i      (ex_wb_valid_i),
    .ex_wb_op_i         (ex_wb_op_i),
    .halt_wb_i          (halt_wb_i),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_ready_o (xif_result_ready_o),
    .rf_we_o            (rf_we_o),
    .retire_valid_o     (retire_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Applies one instruction to the shadow state, returns the exception flag
  function automatic logic reference_model(input op_e op, input logic [RF_ADDR_W-1:0] rd,
                                           input logic [XLEN-1:0] opa,
                                           input logic [XLEN-1:0] opb);
    logic [DMEM_ADDR_W-1:0] addr;
    logic [XLEN-1:0]        res;
    logic                   exc;
    logic                   wr;
    addr = opa[DMEM_ADDR_W-1:0];
    res  = '0;
    exc  = 1'b0;
    wr   = 1'b1;
    case (op)
      OP_ADD: res = opa + opb;
      OP_SUB: res = opa - opb;
      OP_XOR: res = opa ^ opb;
      OP_SLL: res = opa << opb[SHAMT_W-1:0];
      OP_LOAD: begin
        exc = (addr >= DMEM_ADDR_W'(DMEM_WORDS));
        if (!exc) begin
          res = shadow_mem[addr[DMEM_IDX_W-1:0]];
        end
      end
      OP_STORE: begin
        // No destination, memory only changes when in range
        exc = (addr >= DMEM_ADDR_W'(DMEM_WORDS));
        wr  = 1'b0;
        if (!exc) begin
          shadow_mem[addr[DMEM_IDX_W-1:0]] = opb;
        end
      end
      OP_XIF: begin
        exc = (opb == XIF_EXC_MARK);
        res = opa ^ opb;
      end
      default: wr = 1'b0;
    endcase
    // x0 never changes
    if (wr && !exc && (rd != '0)) begin
      shadow_rf[rd] = res;
    end
    return exc;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_retire(input op_e op, input logic [RF_ADDR_W-1:0] exp_rd,
                              input logic [RF_ADDR_W-1:0] got_rd, input logic exp_exc,
                              input logic got_exc);
    if ((got_rd !== exp_rd) || (got_exc !== exp_exc)) begin
      $display("[ERROR] %0t retire %s: rd %0d exc %0b, expected rd %0d exc %0b",
               $time, op.name(), got_rd, got_exc, exp_rd, exp_exc);
      errors++;
    end
  endtask

  task automatic check_reg(input logic [RF_ADDR_W-1:0] addr, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
    if (got !== exp) begin
      $display("[ERROR] %0t x%0d reads %h, expected %h", $time, addr, got, exp);
      errors++;
    end
  endtask

  // Every retirement pops the oldest expectation
  always @(negedge clk) begin
    if (!rst_i && retire_valid_o) begin
      if (exp_op_q.size() == 0) begin
        $display("[ERROR] %0t retirement with no instruction outstanding", $time);
        errors++;
      end else begin
        ret_op  = exp_op_q.pop_front();
        ret_rd  = exp_rd_q.pop_front();
        ret_exc = exp_exc_q.pop_front();
        check_retire(ret_op, ret_rd, retire_rd_o, ret_exc, retire_exc_o);
      end
      retired++;
    end
    if (!rst_i && data_stall_o) begin
      stall_seen = 1'b1;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, instructions stopped retiring", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // Coprocessor model
  ////////////////////

  initial begin
    int delay;
    @(negedge rst_i);
    forever begin
      @(negedge clk);
      if (xif_result_ready_o && !xif_result_valid_i) begin
        delay = int'($urandom_range(0, 5));
        repeat (delay) begin
          @(posedge clk);
        end
        @(posedge clk);
        #1;
        xif_result_valid_i = 1'b1;
        xif_result_data_i  = xif_opa_q[0] ^ xif_opb_q[0];
        xif_result_exc_i   = (xif_opb_q[0] == XIF_EXC_MARK);
        // Hold the result until WB takes it
        @(negedge clk);
        while (!xif_result_ready_o) begin
          @(negedge clk);
        end
        @(posedge clk);
        #1;
        xif_result_valid_i = 1'b0;
        void'(xif_opa_q.pop_front());
        void'(xif_opb_q.pop_front());
      end
    end
  end

  ////////////////////
  // Driver tasks
  ////////////////////

  // Called just after a rising edge, returns just after the transfer edge
  task automatic issue_instr(input op_e op, input logic [RF_ADDR_W-1:0] rd,
                             input logic [XLEN-1:0] opa, input logic [XLEN-1:0] opb);
    logic exc;
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    issue_rd_i    = rd;
    issue_opa_i   = opa;
    issue_opb_i   = opb;
    @(negedge clk);
    while (!issue_ready_o) begin
      @(negedge clk);
    end
    // Transfer on the coming edge
    exc = reference_model(op, rd, opa, opb);
    exp_op_q.push_back(op);
    exp_rd_q.push_back(rd);
    exp_exc_q.push_back(exc);
    if (op == OP_XIF) begin
      xif_opa_q.push_back(opa);
      xif_opb_q.push_back(opb);
    end
    issued++;
    @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Nothing may retire, and a held WB blocks issue
  task automatic hold_halt(input int n, input logic wb_busy);
    halt_wb_i = 1'b1;
    repeat (n) begin
      @(negedge clk);
      if (retire_valid_o) begin
        $display("[ERROR] %0t instruction retired during a halt", $time);
        errors++;
      end
      if (wb_busy && issue_ready_o) begin
        $display("[ERROR] %0t issue_ready_o high during a halt", $time);
        errors++;
      end
      @(posedge clk);
      #1;
    end
    halt_wb_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_op_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < RF_DEPTH; i++) begin
      rf_raddr_i = RF_ADDR_W'(i);
      @(negedge clk);
      check_reg(RF_ADDR_W'(i), shadow_rf[i], rf_rdata_o);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("Test %s done: %0d errors", name, errors - errs_before);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int                     errs_before;
    int                     halt_len;
    op_e                    op;
    logic [RF_ADDR_W-1:0]   rd;
    logic [XLEN-1:0]        opa;
    logic [XLEN-1:0]        opb;
    logic [DMEM_ADDR_W-1:0] k;

    void'($urandom(32'hf597));
    rst_i              = 1'b1;
    issue_valid_i      = 1'b0;
    issue_op_i         = OP_ADD;
    issue_rd_i         = '0;
    issue_opa_i        = '0;
    issue_opb_i        = '0;
    halt_wb_i          = 1'b0;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = '0;
    xif_result_exc_i   = 1'b0;
    rf_raddr_i         = '0;
    stall_seen         = 1'b0;
    errors             = 0;
    issued             = 0;
    retired            = 0;
    tests              = 0;
    cycles             = 0;
    for (int i = 0; i < RF_DEPTH; i++) begin
      shadow_rf[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      shadow_mem[i] = '0;
    end

    repeat (10) begin
      @(posedge clk);
    end
    #1;
    rst_i = 1'b0;

    // Idle outputs after reset
    errs_before = errors;
    @(negedge clk);
    if (!issue_ready_o || retire_valid_o || xif_result_ready_o || data_stall_o ||
        exec_tail_top_inst.lsu_req) begin
      $display("[ERROR] %0t outputs after reset are not at their idle values", $time);
      errors++;
    end
    @(posedge clk);
    #1;
    report_test("reset", errs_before);

    // Back-to-back ALU, first one aimed at x0
    errs_before = errors;
    for (int i = 0; i < N_ALU; i++) begin
      op = op_e'(3'(i % 4));
      rd = (i == 0) ? '0 : RF_ADDR_W'($urandom_range(1, 31));
      issue_instr(op, rd, $urandom(), $urandom());
    end
    wait_drain();
    check_all_regs();
    report_test("alu", errs_before);

    // Stores then loads of the same words
    errs_before = errors;
    for (int i = 0; i < N_STORE; i++) begin
      issue_instr(OP_STORE, RF_ADDR_W'(i), XLEN'(i * 7), $urandom());
      idle_cycles(int'($urandom_range(0, 3)));
    end
    wait_drain();
    stall_seen = 1'b0;
    for (int i = 0; i < N_STORE; i++) begin
      issue_instr(OP_LOAD, RF_ADDR_W'(i + 1), XLEN'(i * 7), '0);
      idle_cycles(int'($urandom_range(0, 3)));
    end
    wait_drain();
    if (!stall_seen) begin
      $display("No data stall was seen while loads waited on the memory");
      errors++;
    end
    check_all_regs();
    report_test("load_store", errs_before);

    // Faulting accesses, then a read of the aliased in-range word
    errs_before = errors;
    for (int i = 0; i < N_FAULT; i++) begin
      k   = DMEM_ADDR_W'($urandom_range(0, DMEM_WORDS - 1));
      opa = XLEN'(k) + XLEN'(DMEM_WORDS * (1 + i % 3));
      issue_instr(OP_LOAD, RF_ADDR_W'(10 + i), opa, '0);
      issue_instr(OP_STORE, '0, opa, $urandom());
      issue_instr(OP_LOAD, RF_ADDR_W'(20 + i), XLEN'(k), '0);
    end
    wait_drain();
    check_all_regs();
    report_test("mpu_fault", errs_before);

    // Offloaded instructions, every third one marked
    errs_before = errors;
    for (int i = 0; i < N_XIF; i++) begin
      opb = (i % 3 == 2) ? XIF_EXC_MARK : $urandom();
      issue_instr(OP_XIF, RF_ADDR_W'($urandom_range(1, 31)), $urandom(), opb);
    end
    wait_drain();
    check_all_regs();
    report_test("coprocessor", errs_before);

    // Halt with one instruction in WB and the next waiting at issue
    errs_before = errors;
    for (int i = 0; i < N_HALT; i++) begin
      case (i % 3)
        0:       op = OP_ADD;
        1:       op = OP_LOAD;
        default: op = OP_XIF;
      endcase
      issue_instr(op, RF_ADDR_W'(i + 1), XLEN'(i), $urandom());
      halt_len = int'($urandom_range(1, 8));
      fork
        issue_instr(OP_SUB, RF_ADDR_W'(i + 8), $urandom(), $urandom());
        hold_halt(halt_len, 1'b1);
      join
    end
    wait_drain();
    check_all_regs();
    report_test("halt", errs_before);

    // Random mix, some addresses out of range
    errs_before = errors;
    for (int i = 0; i < N_MIX; i++) begin
      op  = op_e'(3'($urandom_range(0, 6)));
      rd  = RF_ADDR_W'($urandom_range(0, 31));
      opa = $urandom();
      opb = $urandom();
      if ((op == OP_LOAD) || (op == OP_STORE)) begin
        opa = XLEN'($urandom_range(0, DMEM_WORDS + 7));
      end
      if ((op == OP_XIF) && ($urandom_range(0, 3) == 0)) begin
        opb = XIF_EXC_MARK;
      end
      if ($urandom_range(0, 7) == 0) begin
        halt_len = int'($urandom_range(1, 4));
        fork
          issue_instr(op, rd, opa, opb);
          hold_halt(halt_len, 1'b0);
        join
      end else begin
        issue_instr(op, rd, opa, opb);
      end
    end
    wait_drain();
    check_all_regs();
    report_test("random_mix", errs_before);

    if (retired != issued) begin
      $display("Retired %0d instructions but issued %0d", retired, issued);
      errors++;
    end
    if (exec_tail_top_inst.wb_stage_inst.props_inst.fail_count != 0) begin
      $display("%0d assertion failures on the write-back stage",
               exec_tail_top_inst.wb_stage_inst.props_inst.fail_count);
      errors += exec_tail_top_inst.wb_stage_inst.props_inst.fail_count;
    end
    $display("Summary: %0d tests, %0d issued, %0d retired, %0d errors",
             tests, issued, retired, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/wb_pkg.sv
src/register_file.sv
ex/ex_stage.sv
lsu/load_store_unit.sv
wb/wb_stage.sv
src/exec_tail_top.sv
bench/exec_tail_props.sv
bench/exec_tail_tb.sv

//--- Makefile
TOP := exec_tail_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@grep -q "^Simulation PASSED" sim.log

obj_dir/V$(TOP): vlog.f $(wildcard common/*.sv ex/*.sv lsu/*.sv wb/*.sv src/*.sv bench/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module exec_tail_top

clean:
	rm -rf obj_dir sim.log
